//--- logic/ecc_mem_pkg.sv
`default_nettype none

package ecc_mem_pkg;

  localparam int DATA_W     = 32;
  localparam int ECC_W      = 7;
  localparam int CODE_W     = DATA_W + ECC_W;  // check bits above data.
  localparam int NUM_WORDS  = 4;
  localparam int WORD_SEL_W = 2;
  localparam int ROW_W      = NUM_WORDS * CODE_W;
  localparam int BANK_W     = 3;
  localparam int VADDR_W    = 10;
  localparam int SROW_W     = VADDR_W - WORD_SEL_W;
  localparam int PADR_W     = WORD_SEL_W + SROW_W;

  // classification of one read result.
  typedef enum logic [1:0] {
    RD_CLEAN,
    RD_CORRECTED,
    RD_UNCORR,
    RD_FORWARDED
  } read_kind_e;

  // hamming positions 1..38, data fills the non power of two slots.
  // bit 6 is overall parity over data and the six hamming bits.
  function automatic logic [ECC_W-1:0] ecc_bits(input logic [DATA_W-1:0] d);
    logic [ECC_W-1:0] e;
    int idx;
    e = '0;
    idx = 0;
    for (int p = 1; p < CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        for (int j = 0; j < ECC_W - 1; j++) begin
          if (p[j]) e[j] = e[j] ^ d[idx];
        end
        idx = idx + 1;
      end
    end
    e[ECC_W-1] = ^{e[ECC_W-2:0], d};
    return e;
  endfunction

endpackage

`default_nettype wire

//--- logic/secded_check.sv
`timescale 1ns/1ps
`default_nettype none

module secded_check (
  input  logic [ecc_mem_pkg::CODE_W-1:0] code,
  output logic [ecc_mem_pkg::DATA_W-1:0] data,
  output ecc_mem_pkg::read_kind_e        kind
);

  logic [ecc_mem_pkg::DATA_W-1:0] raw_data;
  logic [ecc_mem_pkg::ECC_W-1:0]  raw_ecc;
  logic [ecc_mem_pkg::ECC_W-1:0]  calc_ecc;
  logic [ecc_mem_pkg::ECC_W-2:0]  syndrome;
  logic                           par_bad;

  assign raw_data = code[ecc_mem_pkg::DATA_W-1:0];
  assign raw_ecc  = code[ecc_mem_pkg::CODE_W-1:ecc_mem_pkg::DATA_W];
  assign calc_ecc = ecc_mem_pkg::ecc_bits(raw_data);

  // hamming part only, overall bit handled by par_bad.
  assign syndrome = raw_ecc[ecc_mem_pkg::ECC_W-2:0] ^ calc_ecc[ecc_mem_pkg::ECC_W-2:0];
  assign par_bad  = ^code;  // whole codeword xors to zero when clean.

  // single error correction.
  // syndrome gives the hamming position of the flipped bit, only data slots need fixing.
  always_comb begin
    int idx;
    idx = 0;
    data = raw_data;
    for (int p = 1; p < ecc_mem_pkg::CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (par_bad && (syndrome == (ecc_mem_pkg::ECC_W - 1)'(p))) begin
          data[idx] = ~raw_data[idx];
        end
        idx = idx + 1;
      end
    end
  end

  // odd error count is taken as one bit, even nonzero as two.
  always_comb begin
    if (par_bad) begin
      kind = ecc_mem_pkg::RD_CORRECTED;
    end else if (syndrome != '0) begin
      kind = ecc_mem_pkg::RD_UNCORR;
    end else begin
      kind = ecc_mem_pkg::RD_CLEAN;
    end
  end

endmodule

`default_nettype wire

//--- logic/write_cmd_stage.sv
`timescale 1ns/1ps
`default_nettype none

module write_cmd_stage (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               write,
  input  logic [ecc_mem_pkg::BANK_W-1:0]     wr_bnk,
  input  logic [ecc_mem_pkg::VADDR_W-1:0]    wr_adr,
  input  logic [ecc_mem_pkg::DATA_W-1:0]     din,
  input  logic                               read,
  input  logic [ecc_mem_pkg::BANK_W-1:0]     rd_bnk,
  input  logic [ecc_mem_pkg::VADDR_W-1:0]    rd_adr,
  output logic                               mem_write,
  output logic [ecc_mem_pkg::BANK_W-1:0]     mem_wr_bnk,
  output logic [ecc_mem_pkg::SROW_W-1:0]     mem_wr_adr,
  output logic [ecc_mem_pkg::ROW_W-1:0]      mem_bw,
  output logic [ecc_mem_pkg::ROW_W-1:0]      mem_din,
  output logic                               mem_read,
  output logic [ecc_mem_pkg::BANK_W-1:0]     mem_rd_bnk,
  output logic [ecc_mem_pkg::SROW_W-1:0]     mem_rd_adr,
  output logic                               fwd_hit,
  output logic [ecc_mem_pkg::WORD_SEL_W-1:0] rd_word,
  output logic [ecc_mem_pkg::SROW_W-1:0]     rd_row,
  output logic [ecc_mem_pkg::CODE_W-1:0]     wr_code
);

  logic [ecc_mem_pkg::WORD_SEL_W-1:0] wr_word;
  logic [ecc_mem_pkg::SROW_W-1:0]     wr_row;
  logic [ecc_mem_pkg::ROW_W-1:0]      wr_mask;
  logic [ecc_mem_pkg::ROW_W-1:0]      wr_data;

  // word index in the low address bits.
  assign wr_word = wr_adr[ecc_mem_pkg::WORD_SEL_W-1:0];
  assign wr_row  = wr_adr[ecc_mem_pkg::VADDR_W-1:ecc_mem_pkg::WORD_SEL_W];
  assign rd_word = rd_adr[ecc_mem_pkg::WORD_SEL_W-1:0];
  assign rd_row  = rd_adr[ecc_mem_pkg::VADDR_W-1:ecc_mem_pkg::WORD_SEL_W];

  assign wr_code = {ecc_mem_pkg::ecc_bits(din), din};

  // place codeword and its mask in the addressed slot.
  assign wr_mask = {{(ecc_mem_pkg::ROW_W - ecc_mem_pkg::CODE_W){1'b0}},
                    {ecc_mem_pkg::CODE_W{1'b1}}} << (wr_word * ecc_mem_pkg::CODE_W);
  assign wr_data = {{(ecc_mem_pkg::ROW_W - ecc_mem_pkg::CODE_W){1'b0}},
                    wr_code} << (wr_word * ecc_mem_pkg::CODE_W);

  assign fwd_hit = read && write && (rd_bnk == wr_bnk) && (rd_adr == wr_adr);

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_write <= 1'b0;
      mem_read  <= 1'b0;
    end else begin
      mem_write <= write;
      mem_read  <= read && !fwd_hit;  // hit is served from write data.
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem_wr_bnk <= wr_bnk;
      mem_wr_adr <= wr_row;
      mem_bw     <= wr_mask;
      mem_din    <= wr_data;
    end
    if (read) begin
      mem_rd_bnk <= rd_bnk;
      mem_rd_adr <= rd_row;
    end
  end

endmodule

`default_nettype wire

//--- logic/read_return_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module read_return_pipe #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               read,
  input  logic                               fwd_hit,
  input  logic [ecc_mem_pkg::WORD_SEL_W-1:0] rd_word,
  input  logic [ecc_mem_pkg::SROW_W-1:0]     rd_row,
  input  logic [ecc_mem_pkg::CODE_W-1:0]     wr_code,
  input  logic [ecc_mem_pkg::ROW_W-1:0]      mem_rd_dout,
  input  logic [ecc_mem_pkg::DATA_W-1:0]     chk_data,
  input  ecc_mem_pkg::read_kind_e            chk_kind,
  output logic [ecc_mem_pkg::CODE_W-1:0]     sel_code,
  output logic                               rd_vld,
  output logic [ecc_mem_pkg::DATA_W-1:0]     rd_dout,
  output logic                               rd_fwrd,
  output logic                               rd_serr,
  output logic                               rd_derr,
  output logic [ecc_mem_pkg::PADR_W-1:0]     rd_padr
);

  // command register, memory latency, return register.
  localparam int DEPTH = SRAM_DELAY + 2;
  localparam int LAST  = DEPTH - 1;

  logic [DEPTH-1:0]                   vld_q;
  logic [DEPTH-1:0]                   fwd_q;
  logic [ecc_mem_pkg::WORD_SEL_W-1:0] word_q [DEPTH];
  logic [ecc_mem_pkg::SROW_W-1:0]     row_q  [DEPTH];
  logic [ecc_mem_pkg::CODE_W-1:0]     code_q [DEPTH];
  logic [ecc_mem_pkg::ROW_W-1:0]      ret_row;
  logic [ecc_mem_pkg::CODE_W-1:0]     mem_code;
  ecc_mem_pkg::read_kind_e            out_kind;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
      fwd_q <= '0;
    end else begin
      vld_q <= {vld_q[DEPTH-2:0], read};
      fwd_q <= {fwd_q[DEPTH-2:0], read && fwd_hit};
    end
  end

  always_ff @(posedge clk) begin
    word_q[0] <= rd_word;
    row_q[0]  <= rd_row;
    code_q[0] <= wr_code;
    for (int i = 1; i < DEPTH; i++) begin
      word_q[i] <= word_q[i-1];
      row_q[i]  <= row_q[i-1];
      code_q[i] <= code_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    ret_row <= mem_rd_dout;  // one cycle after the memory answers.
  end

  assign mem_code = ret_row[word_q[LAST] * ecc_mem_pkg::CODE_W +: ecc_mem_pkg::CODE_W];

  // a forwarded word goes through the checker too and always comes out clean.
  assign sel_code = fwd_q[LAST] ? code_q[LAST] : mem_code;

  assign out_kind = fwd_q[LAST] ? ecc_mem_pkg::RD_FORWARDED : chk_kind;

  assign rd_vld  = vld_q[LAST];
  assign rd_dout = chk_data;
  assign rd_fwrd = vld_q[LAST] && (out_kind == ecc_mem_pkg::RD_FORWARDED);
  assign rd_serr = vld_q[LAST] && (out_kind == ecc_mem_pkg::RD_CORRECTED);
  assign rd_derr = vld_q[LAST] && (out_kind == ecc_mem_pkg::RD_UNCORR);
  assign rd_padr = {word_q[LAST], row_q[LAST]};

endmodule

`default_nettype wire

//--- logic/ecc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            write,
  input  logic [ecc_mem_pkg::BANK_W-1:0]  wr_bnk,
  input  logic [ecc_mem_pkg::VADDR_W-1:0] wr_adr,
  input  logic [ecc_mem_pkg::DATA_W-1:0]  din,
  input  logic                            read,
  input  logic [ecc_mem_pkg::BANK_W-1:0]  rd_bnk,
  input  logic [ecc_mem_pkg::VADDR_W-1:0] rd_adr,
  output logic                            rd_vld,
  output logic [ecc_mem_pkg::DATA_W-1:0]  rd_dout,
  output logic                            rd_fwrd,
  output logic                            rd_serr,
  output logic                            rd_derr,
  output logic [ecc_mem_pkg::PADR_W-1:0]  rd_padr,
  output logic                            mem_write,
  output logic [ecc_mem_pkg::BANK_W-1:0]  mem_wr_bnk,
  output logic [ecc_mem_pkg::SROW_W-1:0]  mem_wr_adr,
  output logic [ecc_mem_pkg::ROW_W-1:0]   mem_bw,
  output logic [ecc_mem_pkg::ROW_W-1:0]   mem_din,
  output logic                            mem_read,
  output logic [ecc_mem_pkg::BANK_W-1:0]  mem_rd_bnk,
  output logic [ecc_mem_pkg::SROW_W-1:0]  mem_rd_adr,
  input  logic [ecc_mem_pkg::ROW_W-1:0]   mem_rd_dout
);

  logic                               fwd_hit;
  logic [ecc_mem_pkg::WORD_SEL_W-1:0] rd_word;
  logic [ecc_mem_pkg::SROW_W-1:0]     rd_row;
  logic [ecc_mem_pkg::CODE_W-1:0]     wr_code;
  logic [ecc_mem_pkg::CODE_W-1:0]     sel_code;
  logic [ecc_mem_pkg::DATA_W-1:0]     chk_data;
  ecc_mem_pkg::read_kind_e            chk_kind;

  write_cmd_stage u_cmd (
    .clk(clk), .rst(rst),
    .write(write), .wr_bnk(wr_bnk), .wr_adr(wr_adr), .din(din),
    .read(read), .rd_bnk(rd_bnk), .rd_adr(rd_adr),
    .mem_write(mem_write), .mem_wr_bnk(mem_wr_bnk), .mem_wr_adr(mem_wr_adr),
    .mem_bw(mem_bw), .mem_din(mem_din),
    .mem_read(mem_read), .mem_rd_bnk(mem_rd_bnk), .mem_rd_adr(mem_rd_adr),
    .fwd_hit(fwd_hit), .rd_word(rd_word), .rd_row(rd_row), .wr_code(wr_code)
  );

  read_return_pipe #(
    .SRAM_DELAY(SRAM_DELAY)
  ) u_ret (
    .clk(clk), .rst(rst),
    .read(read), .fwd_hit(fwd_hit), .rd_word(rd_word), .rd_row(rd_row),
    .wr_code(wr_code), .mem_rd_dout(mem_rd_dout),
    .chk_data(chk_data), .chk_kind(chk_kind), .sel_code(sel_code),
    .rd_vld(rd_vld), .rd_dout(rd_dout), .rd_fwrd(rd_fwrd),
    .rd_serr(rd_serr), .rd_derr(rd_derr), .rd_padr(rd_padr)
  );

  // combinational, sits between word select and output mux.
  secded_check u_chk (
    .code(sel_code),
    .data(chk_data),
    .kind(chk_kind)
  );

endmodule

`default_nettype wire

//--- test/sram_row_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_row_model #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                            clk,
  input  logic                            mem_write,
  input  logic [ecc_mem_pkg::BANK_W-1:0]  mem_wr_bnk,
  input  logic [ecc_mem_pkg::SROW_W-1:0]  mem_wr_adr,
  input  logic [ecc_mem_pkg::ROW_W-1:0]   mem_bw,
  input  logic [ecc_mem_pkg::ROW_W-1:0]   mem_din,
  input  logic                            mem_read,
  input  logic [ecc_mem_pkg::BANK_W-1:0]  mem_rd_bnk,
  input  logic [ecc_mem_pkg::SROW_W-1:0]  mem_rd_adr,
  output logic [ecc_mem_pkg::ROW_W-1:0]   mem_rd_dout
);

  localparam int IDX_W   = ecc_mem_pkg::BANK_W + ecc_mem_pkg::SROW_W;
  localparam int ENTRIES = 2 ** IDX_W;

  logic [ecc_mem_pkg::ROW_W-1:0] mem     [ENTRIES];
  logic [ecc_mem_pkg::ROW_W-1:0] rd_pipe [SRAM_DELAY];
  logic [SRAM_DELAY-1:0]         vld_pipe = '0;
  logic                          flip_en  = 1'b0;
  logic [IDX_W-1:0]              flip_idx;
  logic [ecc_mem_pkg::ROW_W-1:0] flip_row;

  // inverts the masked bits of one stored codeword at the next edge.
  task automatic flip_bits(input logic [ecc_mem_pkg::BANK_W-1:0]     bnk,
                           input logic [ecc_mem_pkg::SROW_W-1:0]     row,
                           input logic [ecc_mem_pkg::WORD_SEL_W-1:0] word,
                           input logic [ecc_mem_pkg::CODE_W-1:0]     mask);
    flip_idx = {bnk, row};
    flip_row = {{(ecc_mem_pkg::ROW_W - ecc_mem_pkg::CODE_W){1'b0}}, mask}
               << (word * ecc_mem_pkg::CODE_W);
    flip_en  = 1'b1;
    @(posedge clk);
    #1;
    flip_en  = 1'b0;
  endtask

  always @(posedge clk) begin
    if (mem_write) begin
      mem[{mem_wr_bnk, mem_wr_adr}] <= (mem[{mem_wr_bnk, mem_wr_adr}] & ~mem_bw) |
                                       (mem_din & mem_bw);
    end
    if (flip_en) mem[flip_idx] <= mem[flip_idx] ^ flip_row;
    vld_pipe[0] <= mem_read;
    if (mem_read) rd_pipe[0] <= mem[{mem_rd_bnk, mem_rd_adr}];  // old row on a same-edge write.
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i]  <= rd_pipe[i-1];
      vld_pipe[i] <= vld_pipe[i-1];
    end
  end

  assign mem_rd_dout = vld_pipe[SRAM_DELAY-1] ? rd_pipe[SRAM_DELAY-1] : 'x;

endmodule

`default_nettype wire

//--- test/ecc_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           rd_vld,
  input  logic [ecc_mem_pkg::DATA_W-1:0] rd_dout,
  input  logic                           rd_fwrd,
  input  logic                           rd_serr,
  input  logic                           rd_derr,
  input  logic [ecc_mem_pkg::PADR_W-1:0] rd_padr,
  input  logic                           exp_push,
  input  logic [ecc_mem_pkg::DATA_W-1:0] exp_data,
  input  logic [2:0]                     exp_flags,  // {derr, serr, fwrd}.
  input  logic [ecc_mem_pkg::PADR_W-1:0] exp_padr,
  input  int                             exp_line,
  output int                             test_cnt,
  output int                             err_cnt
);

  logic [ecc_mem_pkg::DATA_W-1:0] q_data  [$];
  logic [2:0]                     q_flags [$];
  logic [ecc_mem_pkg::PADR_W-1:0] q_padr  [$];
  int                             q_line  [$];

  always @(posedge clk) begin
    logic [ecc_mem_pkg::DATA_W-1:0] e_data;
    logic [2:0]                     e_flags;
    logic [ecc_mem_pkg::PADR_W-1:0] e_padr;
    int                             e_line;
    int                             bad;
    bad = 0;
    if (rst) begin
      q_data.delete();
      q_flags.delete();
      q_padr.delete();
      q_line.delete();
      test_cnt <= 0;
      err_cnt  <= 0;
    end else begin
      if (rd_vld && q_data.size() == 0) begin
        $display("rd_vld went high with no read outstanding");
        err_cnt <= err_cnt + 1;
      end else if (rd_vld) begin
        e_data  = q_data.pop_front();
        e_flags = q_flags.pop_front();
        e_padr  = q_padr.pop_front();
        e_line  = q_line.pop_front();
        // data after a double error is not defined.
        if (!e_flags[2] && rd_dout !== e_data) begin
          $display("MISMATCH rd_dout: got 0x%h expected 0x%h", rd_dout, e_data);
          bad++;
        end
        if (rd_fwrd !== e_flags[0]) begin
          $display("MISMATCH rd_fwrd: got 0x%h expected 0x%h", rd_fwrd, e_flags[0]);
          bad++;
        end
        if (rd_serr !== e_flags[1]) begin
          $display("MISMATCH rd_serr: got 0x%h expected 0x%h", rd_serr, e_flags[1]);
          bad++;
        end
        if (rd_derr !== e_flags[2]) begin
          $display("MISMATCH rd_derr: got 0x%h expected 0x%h", rd_derr, e_flags[2]);
          bad++;
        end
        if (rd_padr !== e_padr) begin
          $display("MISMATCH rd_padr: got 0x%h expected 0x%h", rd_padr, e_padr);
          bad++;
        end
        $display("test %0d, stimulus line %0d: %s", test_cnt + 1, e_line,
                 (bad == 0) ? "ok" : "wrong result");
        test_cnt <= test_cnt + 1;
        err_cnt  <= err_cnt + bad;
      end
      if (exp_push) begin
        q_data.push_back(exp_data);
        q_flags.push_back(exp_flags);
        q_padr.push_back(exp_padr);
        q_line.push_back(exp_line);
      end
    end
  end

endmodule

`default_nettype wire

//--- test/ecc_mem_props.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_props #(
  parameter int SRAM_DELAY = 2
) (
  input logic                            clk,
  input logic                            rst,
  input logic                            write,
  input logic [ecc_mem_pkg::BANK_W-1:0]  wr_bnk,
  input logic [ecc_mem_pkg::VADDR_W-1:0] wr_adr,
  input logic                            read,
  input logic [ecc_mem_pkg::BANK_W-1:0]  rd_bnk,
  input logic [ecc_mem_pkg::VADDR_W-1:0] rd_adr,
  input logic                            rd_vld,
  input logic                            rd_serr,
  input logic                            rd_derr,
  input logic                            mem_read
);

  int assert_fails = 0;

  rd_latency: assert property (@(posedge clk) disable iff (rst)
    rd_vld == $past(read, SRAM_DELAY + 2))
    else begin
      assert_fails++;
      $error("rd_vld not %0d cycles after read", SRAM_DELAY + 2);
    end

  flags_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(rd_serr && rd_derr))
    else begin
      assert_fails++;
      $error("rd_serr and rd_derr high together");
    end

  // a forwarded read never reaches the memory.
  fwd_no_mem_read: assert property (@(posedge clk) disable iff (rst)
    (read && write && rd_bnk == wr_bnk && rd_adr == wr_adr) |=> !mem_read)
    else begin
      assert_fails++;
      $error("mem_read issued for a forwarded read");
    end

endmodule

bind ecc_mem_top ecc_mem_props #(
  .SRAM_DELAY(SRAM_DELAY)
) u_props (
  .clk(clk), .rst(rst),
  .write(write), .wr_bnk(wr_bnk), .wr_adr(wr_adr),
  .read(read), .rd_bnk(rd_bnk), .rd_adr(rd_adr),
  .rd_vld(rd_vld), .rd_serr(rd_serr), .rd_derr(rd_derr),
  .mem_read(mem_read)
);

`default_nettype wire

//--- test/tb_ecc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_mem;

  localparam int    SRAM_DELAY      = 2;
  localparam int    CYCLES_PER_LINE = 20;
  localparam string STIM_FILE       = "test/ecc_mem_stimulus.txt";

  logic                               clk = 1'b0;
  logic                               rst;
  logic                               write;
  logic [ecc_mem_pkg::BANK_W-1:0]     wr_bnk;
  logic [ecc_mem_pkg::VADDR_W-1:0]    wr_adr;
  logic [ecc_mem_pkg::DATA_W-1:0]     din;
  logic                               read;
  logic [ecc_mem_pkg::BANK_W-1:0]     rd_bnk;
  logic [ecc_mem_pkg::VADDR_W-1:0]    rd_adr;
  logic                               rd_vld;
  logic [ecc_mem_pkg::DATA_W-1:0]     rd_dout;
  logic                               rd_fwrd;
  logic                               rd_serr;
  logic                               rd_derr;
  logic [ecc_mem_pkg::PADR_W-1:0]     rd_padr;
  logic                               mem_write;
  logic [ecc_mem_pkg::BANK_W-1:0]     mem_wr_bnk;
  logic [ecc_mem_pkg::SROW_W-1:0]     mem_wr_adr;
  logic [ecc_mem_pkg::ROW_W-1:0]      mem_bw;
  logic [ecc_mem_pkg::ROW_W-1:0]      mem_din;
  logic                               mem_read;
  logic [ecc_mem_pkg::BANK_W-1:0]     mem_rd_bnk;
  logic [ecc_mem_pkg::SROW_W-1:0]     mem_rd_adr;
  logic [ecc_mem_pkg::ROW_W-1:0]      mem_rd_dout;
  logic                               exp_push;
  logic [ecc_mem_pkg::DATA_W-1:0]     exp_data;
  logic [2:0]                         exp_flags;
  logic [ecc_mem_pkg::PADR_W-1:0]     exp_padr;
  int                                 exp_line;
  int                                 test_cnt;
  int                                 err_cnt;

  string stim_text [$];
  int    stim_line [$];
  int    n_ops      = 0;
  int    n_reads    = 0;
  int    stim_errs  = 0;
  bit    loaded     = 1'b0;
  int    seed;

  ecc_mem_top #(.SRAM_DELAY(SRAM_DELAY)) dut (.*);

  sram_row_model #(.SRAM_DELAY(SRAM_DELAY)) mem_model (
    .clk(clk), .mem_write(mem_write), .mem_wr_bnk(mem_wr_bnk), .mem_wr_adr(mem_wr_adr),
    .mem_bw(mem_bw), .mem_din(mem_din), .mem_read(mem_read), .mem_rd_bnk(mem_rd_bnk),
    .mem_rd_adr(mem_rd_adr), .mem_rd_dout(mem_rd_dout)
  );

  ecc_mem_checker chk (
    .clk(clk), .rst(rst), .rd_vld(rd_vld), .rd_dout(rd_dout), .rd_fwrd(rd_fwrd),
    .rd_serr(rd_serr), .rd_derr(rd_derr), .rd_padr(rd_padr), .exp_push(exp_push),
    .exp_data(exp_data), .exp_flags(exp_flags), .exp_padr(exp_padr), .exp_line(exp_line),
    .test_cnt(test_cnt), .err_cnt(err_cnt)
  );

  always #4 clk = ~clk;

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_strobes();
    write    = 1'b0;
    read     = 1'b0;
    exp_push = 1'b0;
  endtask

  task automatic load_stimulus();
    int    fd;
    int    line_no;
    string text;
    line_no = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      return;
    end
    while ($fgets(text, fd) != 0) begin
      line_no++;
      if (text.len() > 1 && text.getc(0) != "#") begin  // skip blanks and comments.
        stim_text.push_back(text);
        stim_line.push_back(line_no);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_line(input string text, input int line_no);
    int                                 op;
    logic [ecc_mem_pkg::BANK_W-1:0]     bnk;
    logic [ecc_mem_pkg::VADDR_W-1:0]    adr;
    logic [ecc_mem_pkg::DATA_W-1:0]     dat;
    logic [ecc_mem_pkg::CODE_W-1:0]     msk;
    logic [ecc_mem_pkg::DATA_W-1:0]     edat;
    logic [2:0]                         eflg;
    int                                 got;
    int                                 gap;
    got = $sscanf(text, "%h %h %h %h %h %h %h", op, bnk, adr, dat, msk, edat, eflg);
    if (got != 7 || op > 4) begin
      $display("stimulus line %0d cannot be parsed", line_no);
      stim_errs++;
      return;
    end
    clear_strobes();
    if (op == 1 || op == 3) begin
      write  = 1'b1;
      wr_bnk = bnk;
      wr_adr = adr;
      din    = dat;
    end
    if (op == 2 || op == 3) begin
      read      = 1'b1;
      rd_bnk    = bnk;
      rd_adr    = adr;
      exp_push  = 1'b1;
      exp_data  = edat;
      exp_flags = eflg;
      exp_padr  = {adr[ecc_mem_pkg::WORD_SEL_W-1:0], adr[ecc_mem_pkg::VADDR_W-1:2]};
      exp_line  = line_no;
      n_reads++;
    end
    if (op == 4) begin
      step();  // pending writes commit first.
      step();
      mem_model.flip_bits(bnk, adr[ecc_mem_pkg::VADDR_W-1:2],
                          adr[ecc_mem_pkg::WORD_SEL_W-1:0], msk);
    end else begin
      step();
    end
    clear_strobes();
    if (op == 1 || op == 4) begin
      gap = $unsigned($random(seed)) % 3;  // reads stay back to back.
      repeat (gap) step();
    end
  endtask

  initial begin
    seed = 93352;
    rst  = 1'b1;
    clear_strobes();
    wr_bnk    = '0;
    wr_adr    = '0;
    din       = '0;
    rd_bnk    = '0;
    rd_adr    = '0;
    exp_data  = '0;
    exp_flags = '0;
    exp_padr  = '0;
    exp_line  = 0;
    load_stimulus();
    n_ops = stim_text.size();
    if (n_ops == 0) begin
      $display("no operations found in the stimulus file");
      stim_errs++;
    end else begin
      loaded = 1'b1;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (stim_text[i]) run_line(stim_text[i], stim_line[i]);
    while (test_cnt < n_reads) step();
    repeat (4) step();
    $display("tests %0d of %0d, errors %0d, bad lines %0d, assertion failures %0d",
             test_cnt, n_reads, err_cnt, stim_errs, dut.u_props.assert_fails);
    if (err_cnt == 0 && stim_errs == 0 && dut.u_props.assert_fails == 0 &&
        test_cnt == n_reads && n_reads > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (n_ops * CYCLES_PER_LINE) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d reads checked",
             n_ops * CYCLES_PER_LINE, test_cnt, n_reads);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
logic/ecc_mem_pkg.sv
logic/secded_check.sv
logic/write_cmd_stage.sv
logic/read_return_pipe.sv
logic/ecc_mem_top.sv
test/sram_row_model.sv
test/ecc_mem_checker.sv
test/ecc_mem_props.sv
test/tb_ecc_mem.sv

//--- Makefile
# Verilator build for the SECDED memory front end.

VERILATOR ?= verilator
TOP       ?= tb_ecc_mem
RTL_TOP   ?= ecc_mem_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ALL CHECKS PASSED

RTL_SRCS ?= logic/ecc_mem_pkg.sv logic/secded_check.sv logic/write_cmd_stage.sv \
            logic/read_return_pipe.sv logic/ecc_mem_top.sv
TB_SRCS  ?= test/sram_row_model.sv test/ecc_mem_checker.sv test/ecc_mem_props.sv \
            test/tb_ecc_mem.sv

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/ecc_mem_stimulus.txt
# op bank adr data flip_mask exp_data exp_flags, all hex
# op 0 idle 1 write 2 read 3 write+read 4 flip, exp_flags {derr,serr,fwrd}
1 1 010 deadbeef 0 0 0
0 0 000 00000000 0 0 0
2 1 010 00000000 0 deadbeef 0
1 2 120 11111111 0 0 0
1 2 121 22222222 0 0 0
1 2 122 33333333 0 0 0
1 2 123 44444444 0 0 0
2 2 120 00000000 0 11111111 0
2 2 121 00000000 0 22222222 0
2 2 122 00000000 0 33333333 0
2 2 123 00000000 0 44444444 0
1 3 054 80000001 0 0 0
1 3 055 12345678 0 0 0
1 3 056 cafef00d 0 0 0
1 3 057 0f0f0f0f 0 0 0
4 3 054 00000000 0080000000 0 0
4 3 055 00000000 0000000001 0 0
4 3 056 00000000 4000000000 0 0
4 3 057 00000000 0200000000 0 0
2 3 054 00000000 0 80000001 2
2 3 055 00000000 0 12345678 2
2 3 056 00000000 0 cafef00d 2
2 3 057 00000000 0 0f0f0f0f 2
1 4 3ff a5a5a5a5 0 0 0
4 4 3ff 00000000 0000000011 0 0
2 4 3ff 00000000 0 00000000 4
3 5 200 0badf00d 0 0badf00d 1
2 5 200 00000000 0 0badf00d 0
2 1 010 00000000 0 deadbeef 0
